// ==== testbench/centroid_patterns.txt ====
# id kind width height present col0 col1 row0 row1 credit expect found count col row
# kind 1 starts mid-frame, credit 1 withholds credits, expect 0 means no result
1 1 12 6 1 2 5 1 3 0 0 0 0 0 0
2 0 16 10 1 3 8 2 6 0 1 1 30 5 4
3 0 20 12 1 10 17 3 10 0 1 1 64 13 6
4 0 16 8 0 0 0 0 0 0 1 0 0 0 0
5 0 12 8 1 0 0 0 0 1 1 1 1 0 0
6 0 12 8 1 4 11 5 7 1 1 1 24 7 6
7 0 14 9 1 1 4 2 8 1 1 1 28 2 5
8 0 14 9 1 6 9 0 3 1 0 0 0 0 0
9 0 16 10 1 9 15 4 9 0 1 1 42 12 6
10 0 640 480 1 1 639 1 479 0 1 1 306081 320 240

// ==== vlog.f ====
rtl/trackPkg.sv
rtl/pixelCapture.sv
rtl/colorMatch.sv
rtl/centroidAccum.sv
rtl/serialDivider.sv
rtl/frameControl.sv
rtl/colorTracker.sv
testbench/trackChecker.sv
testbench/tbColorTracker.sv

// ==== Bender.yml ====
package:
  name: colorTracker

sources:
  - target: any(rtl, test)
    files:
      - rtl/trackPkg.sv
      - rtl/pixelCapture.sv
      - rtl/colorMatch.sv
      - rtl/centroidAccum.sv
      - rtl/serialDivider.sv
      - rtl/frameControl.sv
      - rtl/colorTracker.sv
  - target: test
    files:
      - testbench/trackChecker.sv
      - testbench/tbColorTracker.sv

// ==== testbench/tbColorTracker.sv ====
`timescale 1ns/1ps

module tbColorTracker;

  localparam int maxTests = 32;

  logic CLK;
  logic rst;
  logic pclk;
  logic href;
  logic vsync;
  logic [trackPkg::pixelWidth-1:0] pixel;
  logic creditReturn;

  logic                            resultValid;
  logic                            resultFound;
  logic [trackPkg::colWidth-1:0]   resultCol;
  logic [trackPkg::rowWidth-1:0]   resultRow;
  logic [trackPkg::countWidth-1:0] resultCount;

  // Pattern table, one entry per file line
  int numTests;
  int tId[maxTests];
  int tKind[maxTests];
  int tWidth[maxTests];
  int tHeight[maxTests];
  int tPresent[maxTests];
  int tCol0[maxTests];
  int tCol1[maxTests];
  int tRow0[maxTests];
  int tRow1[maxTests];
  int tCredit[maxTests];
  int tExpect[maxTests];
  int tFound[maxTests];
  int tCount[maxTests];
  int tCol[maxTests];
  int tRow[maxTests];

  // Consumer side of the credit loop
  logic releaseCredits;
  int owed;
  longint limitCycles;

  colorTracker i_colorTracker
  (
    .CLK(CLK), .rst(rst), .pclk(pclk), .href(href), .vsync(vsync), .pixel(pixel),
    .creditReturn(creditReturn), .resultValid(resultValid), .resultFound(resultFound),
    .resultCol(resultCol), .resultRow(resultRow), .resultCount(resultCount)
  );

  trackChecker i_trackChecker
  (
    .CLK(CLK), .rst(rst), .creditReturn(creditReturn), .resultValid(resultValid),
    .resultFound(resultFound), .resultCol(resultCol), .resultRow(resultRow),
    .resultCount(resultCount)
  );

  // 20 ns system clock
  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  //////////////////////////////////////////////////
  // Pattern file and pixel colors
  //////////////////////////////////////////////////

  task automatic loadPatterns();
    int fd;
    int n;
    int v[15];
    string line;
    fd = $fopen("testbench/centroid_patterns.txt", "r");
    if (fd == 0)
      $display("Pattern file testbench/centroid_patterns.txt could not be opened");
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        // Skip blanks and column notes
        if (line.len() > 1 && line[0] != "#" && numTests < maxTests)
        begin
          n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                      v[8], v[9], v[10], v[11], v[12], v[13], v[14]);
          if (n == 15)
          begin
            tId[numTests] = v[0];
            tKind[numTests] = v[1];
            tWidth[numTests] = v[2];
            tHeight[numTests] = v[3];
            tPresent[numTests] = v[4];
            tCol0[numTests] = v[5];
            tCol1[numTests] = v[6];
            tRow0[numTests] = v[7];
            tRow1[numTests] = v[8];
            tCredit[numTests] = v[9];
            tExpect[numTests] = v[10];
            tFound[numTests] = v[11];
            tCount[numTests] = v[12];
            tCol[numTests] = v[13];
            tRow[numTests] = v[14];
            numTests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  function automatic logic [trackPkg::pixelWidth-1:0] pixelAt(input int t, input int x,
                                                               input int y);
    logic [trackPkg::redWidth-1:0]   redBelow;
    logic [trackPkg::greenWidth-1:0] greenAbove;
    logic [trackPkg::blueWidth-1:0]  blueAbove;
    logic inRect;
    logic [trackPkg::pixelWidth-1:0] pix;
    // One step past each window bound
    redBelow = trackPkg::redMin - 1;
    greenAbove = trackPkg::greenMax + 1;
    blueAbove = trackPkg::blueMax + 1;
    inRect = tPresent[t] != 0 && x >= tCol0[t] && x <= tCol1[t]
             && y >= tRow0[t] && y <= tRow1[t];
    if (inRect)
      // Target colors sit on the window corners
      case ((x + y) % 4)
        0: pix = {trackPkg::redMax, trackPkg::greenMin, trackPkg::blueMin};
        1: pix = {trackPkg::redMin, trackPkg::greenMax, trackPkg::blueMax};
        2: pix = {trackPkg::redMin, trackPkg::greenMin, trackPkg::blueMax};
        default: pix = {trackPkg::redMax, trackPkg::greenMax, trackPkg::blueMin};
      endcase
    else
      // Background just misses one bound, or plain gray
      case ((x + 2 * y) % 4)
        0: pix = {redBelow, trackPkg::greenMin, trackPkg::blueMin};
        1: pix = {trackPkg::redMax, greenAbove, trackPkg::blueMin};
        2: pix = {trackPkg::redMax, trackPkg::greenMin, blueAbove};
        default: pix = {5'd16, 6'd32, 5'd16};
      endcase
    return pix;
  endfunction

  //////////////////////////////////////////////////
  // Camera driver
  //////////////////////////////////////////////////

  // PCLK periods with HREF low
  task automatic idlePclk(input int periods);
    repeat (periods)
    begin
      @(posedge CLK);
      pclk <= 1'b0;
      href <= 1'b0;
      @(posedge CLK);
      @(posedge CLK);
      pclk <= 1'b1;
      @(posedge CLK);
    end
  endtask

  // Data set up while PCLK is low
  task automatic sendPixel(input logic [trackPkg::pixelWidth-1:0] pix);
    @(posedge CLK);
    pclk <= 1'b0;
    href <= 1'b1;
    pixel <= pix;
    @(posedge CLK);
    @(posedge CLK);
    pclk <= 1'b1;
    @(posedge CLK);
  endtask

  task automatic driveFrame(input int t);
    int x;
    int y;
    @(posedge CLK);
    if (tCredit[t] == 0)
      releaseCredits <= 1'b1;
    // Kind 1 frames begin without a VSYNC fall
    if (tKind[t] == 0)
    begin
      vsync <= 1'b1;
      // Long enough for the previous result and its credit
      repeat (64 + $urandom % 16) @(posedge CLK);
      vsync <= 1'b0;
      releaseCredits <= (tCredit[t] == 0);
      idlePclk(2);
    end
    for (y = 0; y < tHeight[t]; y++)
    begin
      for (x = 0; x < tWidth[t]; x++)
        sendPixel(pixelAt(t, x, y));
      idlePclk(4 + $urandom % 4);
    end
    // Frame end
    @(posedge CLK);
    vsync <= 1'b1;
  endtask

  // Returns one credit per result while released
  always @(posedge CLK)
  begin
    if (rst)
    begin
      owed = 0;
      creditReturn <= 1'b0;
    end
    else
    begin
      if (resultValid)
        owed = owed + 1;
      if (releaseCredits && owed > 0 && !creditReturn)
      begin
        creditReturn <= 1'b1;
        owed = owed - 1;
      end
      else
        creditReturn <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial
  begin
    int seedInit;
    int waited;
    int t;
    longint cycles;
    seedInit = $urandom(62);
    rst = 1'b1;
    pclk = 1'b0;
    href = 1'b0;
    vsync = 1'b0;
    pixel = '0;
    creditReturn = 1'b0;
    releaseCredits = 1'b1;
    numTests = 0;
    limitCycles = 0;
    loadPatterns();
    // Active pixels at 4 CLK each, divide, blanking margin
    cycles = 1000;
    for (t = 0; t < numTests; t++)
      cycles += longint'(tWidth[t]) * tHeight[t] * 4 + trackPkg::divCycles
                + tHeight[t] * 32 + 120;
    limitCycles = cycles;
    repeat (2) @(posedge CLK);
    rst <= 1'b0;
    for (t = 0; t < numTests; t++)
    begin
      if (tExpect[t] != 0)
        i_trackChecker.expectResult(tId[t], tFound[t], tCount[t], tCol[t], tRow[t],
                                    tPresent[t], tCol0[t], tCol1[t], tRow0[t], tRow1[t]);
      else
        i_trackChecker.expectNone(tId[t]);
      driveFrame(t);
    end
    // Last result trails the final frame end
    waited = 0;
    while (!i_trackChecker.allReceived() && waited < 4 * trackPkg::divCycles)
    begin
      @(posedge CLK);
      waited++;
    end
    repeat (20) @(posedge CLK);
    i_trackChecker.summary();
    if (numTests > 0 && i_trackChecker.errorTotal() == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial
  begin
    wait (limitCycles > 0);
    repeat (limitCycles) @(posedge CLK);
    $display("Watchdog expired after %0d cycles before all tests completed", limitCycles);
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== testbench/trackChecker.sv ====
`timescale 1ns/1ps

module trackChecker
(
  input logic                            CLK,
  input logic                            rst,
  input logic                            creditReturn,
  input logic                            resultValid,
  input logic                            resultFound,
  input logic [trackPkg::colWidth-1:0]   resultCol,
  input logic [trackPkg::rowWidth-1:0]   resultRow,
  input logic [trackPkg::countWidth-1:0] resultCount
);

  // Expected results in arrival order
  int expId[$];
  int expFound[$];
  int expCount[$];
  int expCol[$];
  int expRow[$];
  // Tests whose frame yields nothing
  int skipId[$];

  int testsRun = 0;
  int testsFailed = 0;
  int errorCount = 0;
  int unexpectedCount = 0;

  // Credits the consumer still grants
  int creditsLeft = trackPkg::resultCredits;

  //////////////////////////////////////////////////
  // Expectations from the driver
  //////////////////////////////////////////////////

  task automatic expectResult(input int id, input int found, input int count, input int col,
                              input int row, input int present, input int c0, input int c1,
                              input int r0, input int r1);
    longint n;
    longint sx;
    longint sy;
    int x;
    int y;
    int rc;
    int ry;
    n = 0;
    sx = 0;
    sy = 0;
    // Centroid is floor of coordinate sums over count
    if (present != 0)
      for (y = r0; y <= r1; y++)
        for (x = c0; x <= c1; x++)
        begin
          n++;
          sx += x;
          sy += y;
        end
    rc = (n > 0) ? int'(sx / n) : 0;
    ry = (n > 0) ? int'(sy / n) : 0;
    if (found != (n > 0) || count != n || col != rc || row != ry)
    begin
      $display("Test %0d expects count %0d col %0d row %0d but its rectangle gives %0d %0d %0d",
               id, count, col, row, n, rc, ry);
      errorCount++;
    end
    expId.push_back(id);
    expFound.push_back(found);
    expCount.push_back(count);
    expCol.push_back(col);
    expRow.push_back(row);
  endtask

  task automatic expectNone(input int id);
    skipId.push_back(id);
  endtask

  function automatic bit allReceived();
    return expId.size() == 0;
  endfunction

  function automatic int errorTotal();
    return errorCount;
  endfunction

  //////////////////////////////////////////////////
  // Result comparison
  //////////////////////////////////////////////////

  task automatic compareField(input int id, input string name, input int expV,
                              input logic [31:0] gotV, inout bit bad);
    if (gotV !== expV)
    begin
      $display("error at %0d ns: test %0d %s expected %0d got %0d",
               $time, id, name, expV, gotV);
      errorCount++;
      bad = 1'b1;
    end
  endtask

  task automatic takeResult();
    int id;
    bit bad;
    bit noCredit;
    bad = 1'b0;
    // Each result spends one credit
    noCredit = (creditsLeft == 0);
    if (!noCredit)
      creditsLeft--;
    if (expId.size() == 0)
    begin
      $display("A result arrived at %0d ns while no frame was waiting for one", $time);
      unexpectedCount++;
      errorCount++;
    end
    else
    begin
      id = expId.pop_front();
      if (noCredit)
      begin
        $display("Test %0d result arrived at %0d ns although no credit was left",
                 id, $time);
        errorCount++;
        bad = 1'b1;
      end
      compareField(id, "resultFound", expFound.pop_front(), resultFound, bad);
      compareField(id, "resultCount", expCount.pop_front(), resultCount, bad);
      compareField(id, "resultCol", expCol.pop_front(), resultCol, bad);
      compareField(id, "resultRow", expRow.pop_front(), resultRow, bad);
      testsRun++;
      if (bad)
        testsFailed++;
      else
        $display("test %0d passed: found %0d count %0d col %0d row %0d",
                 id, resultFound, resultCount, resultCol, resultRow);
    end
  endtask

  // Sampled away from the active edge
  always @(negedge CLK)
  begin
    if (rst)
      creditsLeft = trackPkg::resultCredits;
    else
    begin
      if (resultValid)
        takeResult();
      // Returned credit never exceeds the initial count
      if (creditReturn && creditsLeft < trackPkg::resultCredits)
        creditsLeft++;
    end
  end

  task automatic summary();
    int id;
    int dummy;
    // Results that never showed up
    while (expId.size() > 0)
    begin
      id = expId.pop_front();
      dummy = expFound.pop_front();
      dummy = expCount.pop_front();
      dummy = expCol.pop_front();
      dummy = expRow.pop_front();
      $display("test %0d failed: its result never arrived", id);
      testsRun++;
      testsFailed++;
      errorCount++;
    end
    foreach (skipId[i])
    begin
      testsRun++;
      if (unexpectedCount == 0)
        $display("test %0d passed: its frame produced no result", skipId[i]);
      else
      begin
        $display("test %0d failed: a result arrived that no frame asked for", skipId[i]);
        testsFailed++;
      end
    end
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             testsRun, testsRun - testsFailed, testsFailed, errorCount);
  endtask

endmodule

// ==== rtl/colorTracker.sv ====
`timescale 1ns/1ps

module colorTracker
(
  input  logic                            CLK,
  input  logic                            rst,
  input  logic                            pclk,
  input  logic                            href,
  input  logic                            vsync,
  input  logic [trackPkg::pixelWidth-1:0] pixel,
  input  logic                            creditReturn,
  output logic                            resultValid,
  output logic                            resultFound,
  output logic [trackPkg::colWidth-1:0]   resultCol,
  output logic [trackPkg::rowWidth-1:0]   resultRow,
  output logic [trackPkg::countWidth-1:0] resultCount
);

  // Capture to match
  logic                            pixStrobe;
  logic [trackPkg::pixelWidth-1:0] pixData;
  logic [trackPkg::colWidth-1:0]   col;
  logic [trackPkg::rowWidth-1:0]   row;
  logic                            frameStart;
  logic                            frameEnd;

  // Match to accumulator
  logic                            matchStrobe;
  logic                            matched;
  logic [trackPkg::colWidth-1:0]   matchCol;
  logic [trackPkg::rowWidth-1:0]   matchRow;

  // Accumulator, dividers and control
  logic [trackPkg::countWidth-1:0] count;
  logic [trackPkg::sumWidth-1:0]   colSum;
  logic [trackPkg::sumWidth-1:0]   rowSum;
  logic [trackPkg::sumWidth-1:0]   colQuot;
  logic [trackPkg::sumWidth-1:0]   rowQuot;
  logic                            colDone;
  logic                            clear;
  logic                            enable;
  logic                            divStart;

  pixelCapture i_pixelCapture
  (
    .CLK(CLK), .rst(rst), .pclk(pclk), .href(href), .vsync(vsync), .pixel(pixel),
    .pixStrobe(pixStrobe), .pixData(pixData), .col(col), .row(row),
    .frameStart(frameStart), .frameEnd(frameEnd)
  );

  colorMatch i_colorMatch
  (
    .CLK(CLK), .rst(rst), .pixStrobe(pixStrobe), .pixData(pixData), .col(col), .row(row),
    .matchStrobe(matchStrobe), .matched(matched), .matchCol(matchCol), .matchRow(matchRow)
  );

  centroidAccum i_centroidAccum
  (
    .CLK(CLK), .rst(rst), .clear(clear), .enable(enable), .matchStrobe(matchStrobe),
    .matched(matched), .matchCol(matchCol), .matchRow(matchRow),
    .count(count), .colSum(colSum), .rowSum(rowSum)
  );

  serialDivider i_colDivider
  (
    .CLK(CLK), .rst(rst), .start(divStart), .dividend(colSum), .divisor(count),
    .quotient(colQuot), .done(colDone)
  );

  // Same latency as the column divider, its done is not needed
  serialDivider i_rowDivider
  (
    .CLK(CLK), .rst(rst), .start(divStart), .dividend(rowSum), .divisor(count),
    .quotient(rowQuot), .done()
  );

  frameControl i_frameControl
  (
    .CLK(CLK), .rst(rst), .frameStart(frameStart), .frameEnd(frameEnd),
    .colDone(colDone), .colQuot(colQuot), .rowQuot(rowQuot), .count(count),
    .creditReturn(creditReturn), .clear(clear), .enable(enable), .divStart(divStart),
    .resultValid(resultValid), .resultFound(resultFound), .resultCol(resultCol),
    .resultRow(resultRow), .resultCount(resultCount)
  );

endmodule

// ==== rtl/frameControl.sv ====
`timescale 1ns/1ps

module frameControl
(
  input  logic                            CLK,
  input  logic                            rst,
  input  logic                            frameStart,
  input  logic                            frameEnd,
  input  logic                            colDone,
  input  logic [trackPkg::sumWidth-1:0]   colQuot,
  input  logic [trackPkg::sumWidth-1:0]   rowQuot,
  input  logic [trackPkg::countWidth-1:0] count,
  input  logic                            creditReturn,
  output logic                            clear,
  output logic                            enable,
  output logic                            divStart,
  output logic                            resultValid,
  output logic                            resultFound,
  output logic [trackPkg::colWidth-1:0]   resultCol,
  output logic [trackPkg::rowWidth-1:0]   resultRow,
  output logic [trackPkg::countWidth-1:0] resultCount
);

  typedef enum logic [2:0] {stIdle, stAccum, stDivide, stWaitCredit, stIssue} stateT;

  stateT state;
  logic [trackPkg::creditWidth-1:0] credits;
  logic sendNow;

  // Result leaves this cycle
  assign sendNow = (state == stWaitCredit) && (credits != '0);

  //////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      state <= stIdle;
      clear <= 1'b0;
      enable <= 1'b0;
      divStart <= 1'b0;
      resultValid <= 1'b0;
    end
    else
    begin
      // Pulses default low
      clear <= 1'b0;
      divStart <= 1'b0;
      resultValid <= 1'b0;
      case (state)
        stIdle, stIssue:
          // Arm only on a clean frame start
          if (frameStart)
          begin
            clear <= 1'b1;
            enable <= 1'b1;
            state <= stAccum;
          end
          else
            state <= stIdle;
        stAccum:
          if (frameEnd)
          begin
            enable <= 1'b0;
            divStart <= 1'b1;
            state <= stDivide;
          end
        stDivide:
          // Row divider finishes on the same cycle
          if (colDone)
            state <= stWaitCredit;
        stWaitCredit:
          // Frame starts seen here are dropped
          if (sendNow)
          begin
            resultValid <= 1'b1;
            state <= stIssue;
          end
        default:
          state <= stIdle;
      endcase
    end
  end

  // Result registers
  always_ff @(posedge CLK)
  begin
    if (state == stDivide && colDone)
    begin
      resultFound <= (count != '0);
      resultCol <= colQuot[trackPkg::colWidth-1:0];
      resultRow <= rowQuot[trackPkg::rowWidth-1:0];
      resultCount <= count;
    end
  end

  // Credit counter, return and send may coincide
  always_ff @(posedge CLK)
  begin
    if (rst)
      credits <= trackPkg::resultCredits[trackPkg::creditWidth-1:0];
    else if (creditReturn && !sendNow && credits != trackPkg::resultCredits)
      credits <= credits + 1'b1;
    else if (sendNow && !creditReturn)
      credits <= credits - 1'b1;
  end

endmodule

// ==== rtl/serialDivider.sv ====
`timescale 1ns/1ps

module serialDivider
(
  input  logic                            CLK,
  input  logic                            rst,
  input  logic                            start,
  input  logic [trackPkg::sumWidth-1:0]   dividend,
  input  logic [trackPkg::countWidth-1:0] divisor,
  output logic [trackPkg::sumWidth-1:0]   quotient,
  output logic                            done
);

  logic busy;
  logic [trackPkg::divCountWidth-1:0] cycleCnt;

  // Dividend shifts out the top, quotient bits shift in below
  logic [trackPkg::sumWidth-1:0]   quotReg;
  logic [trackPkg::countWidth-1:0] remReg;
  logic [trackPkg::countWidth-1:0] divReg;

  logic [trackPkg::countWidth:0]   remShift;
  logic [trackPkg::countWidth+1:0] trial;
  logic quotBit;

  // Partial remainder with the next dividend bit
  assign remShift = {remReg, quotReg[trackPkg::sumWidth-1]};
  // Extra top bit is the borrow
  assign trial = {1'b0, remShift} - {2'b00, divReg};
  // Zero divisor never sets a bit
  assign quotBit = ~trial[trackPkg::countWidth+1] && (divReg != '0);

  //////////////////////////////////////////////////
  // Cycle control
  //////////////////////////////////////////////////

  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      busy <= 1'b0;
      done <= 1'b0;
      cycleCnt <= '0;
    end
    else
    begin
      done <= 1'b0;
      if (start)
      begin
        busy <= 1'b1;
        cycleCnt <= '0;
      end
      else if (busy)
      begin
        // Last bit this cycle
        if (cycleCnt == trackPkg::divCycles - 1)
        begin
          busy <= 1'b0;
          done <= 1'b1;
        end
        else
          cycleCnt <= cycleCnt + 1'b1;
      end
    end
  end

  // Restoring step
  always_ff @(posedge CLK)
  begin
    if (start)
    begin
      quotReg <= dividend;
      remReg <= '0;
      divReg <= divisor;
    end
    else if (busy)
    begin
      quotReg <= {quotReg[trackPkg::sumWidth-2:0], quotBit};
      remReg <= quotBit ? trial[trackPkg::countWidth-1:0] : remShift[trackPkg::countWidth-1:0];
    end
  end

  assign quotient = quotReg;

endmodule

// ==== rtl/centroidAccum.sv ====
`timescale 1ns/1ps

module centroidAccum
(
  input  logic                            CLK,
  input  logic                            rst,
  input  logic                            clear,
  input  logic                            enable,
  input  logic                            matchStrobe,
  input  logic                            matched,
  input  logic [trackPkg::colWidth-1:0]   matchCol,
  input  logic [trackPkg::rowWidth-1:0]   matchRow,
  output logic [trackPkg::countWidth-1:0] count,
  output logic [trackPkg::sumWidth-1:0]   colSum,
  output logic [trackPkg::sumWidth-1:0]   rowSum
);

  // Zero extended coordinates
  logic [trackPkg::sumWidth-1:0] colExt;
  logic [trackPkg::sumWidth-1:0] rowExt;

  logic addPixel;

  assign colExt = {{(trackPkg::sumWidth - trackPkg::colWidth){1'b0}}, matchCol};
  assign rowExt = {{(trackPkg::sumWidth - trackPkg::rowWidth){1'b0}}, matchRow};

  // Matched pixels inside an armed frame
  assign addPixel = enable & matchStrobe & matched;

  //////////////////////////////////////////////////
  // Running totals
  //////////////////////////////////////////////////

  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      count <= '0;
      colSum <= '0;
      rowSum <= '0;
    end
    else if (clear)
    begin
      // New frame
      count <= '0;
      colSum <= '0;
      rowSum <= '0;
    end
    else if (addPixel)
    begin
      count <= count + 1'b1;
      colSum <= colSum + colExt;
      rowSum <= rowSum + rowExt;
    end
  end

  // Totals stay put after enable drops
  // so the dividers see stable operands

endmodule

// ==== rtl/colorMatch.sv ====
`timescale 1ns/1ps

module colorMatch
(
  input  logic                            CLK,
  input  logic                            rst,
  input  logic                            pixStrobe,
  input  logic [trackPkg::pixelWidth-1:0] pixData,
  input  logic [trackPkg::colWidth-1:0]   col,
  input  logic [trackPkg::rowWidth-1:0]   row,
  output logic                            matchStrobe,
  output logic                            matched,
  output logic [trackPkg::colWidth-1:0]   matchCol,
  output logic [trackPkg::rowWidth-1:0]   matchRow
);

  logic [trackPkg::redWidth-1:0]   red;
  logic [trackPkg::greenWidth-1:0] green;
  logic [trackPkg::blueWidth-1:0]  blue;
  logic redOk;
  logic greenOk;
  logic blueOk;

  // RGB565 channel split, red on top
  assign red = pixData[15:11];
  assign green = pixData[10:5];
  assign blue = pixData[4:0];

  // Bounds are inclusive on both sides
  assign redOk = (red >= trackPkg::redMin) && (red <= trackPkg::redMax);
  assign greenOk = (green >= trackPkg::greenMin) && (green <= trackPkg::greenMax);
  assign blueOk = (blue >= trackPkg::blueMin) && (blue <= trackPkg::blueMax);

  // One cycle of latency
  always_ff @(posedge CLK)
  begin
    if (rst)
      matchStrobe <= 1'b0;
    else
      matchStrobe <= pixStrobe;
  end

  always_ff @(posedge CLK)
  begin
    matched <= redOk & greenOk & blueOk;
    matchCol <= col;
    matchRow <= row;
  end

endmodule

// ==== rtl/pixelCapture.sv ====
`timescale 1ns/1ps

module pixelCapture
(
  input  logic                            CLK,
  input  logic                            rst,
  input  logic                            pclk,
  input  logic                            href,
  input  logic                            vsync,
  input  logic [trackPkg::pixelWidth-1:0] pixel,
  output logic                            pixStrobe,
  output logic [trackPkg::pixelWidth-1:0] pixData,
  output logic [trackPkg::colWidth-1:0]   col,
  output logic [trackPkg::rowWidth-1:0]   row,
  output logic                            frameStart,
  output logic                            frameEnd
);

  // Stage 0 meta, stage 1 synced, stage 2 previous
  logic [2:0] pclkPipe;
  logic [2:0] hrefPipe;
  logic [2:0] vsyncPipe;

  // Data follows the same two stages as pclk
  logic [trackPkg::pixelWidth-1:0] pixMeta;
  logic [trackPkg::pixelWidth-1:0] pixSync;

  logic [trackPkg::colWidth-1:0] colCnt;
  logic [trackPkg::rowWidth-1:0] rowCnt;
  logic [trackPkg::colWidth-1:0] colNow;

  logic pclkRise;
  logic hrefRise;
  logic hrefFall;
  logic vsyncRise;
  logic vsyncFall;
  logic pixTake;

  //////////////////////////////////////////////////
  // Synchronizers and edge detect
  //////////////////////////////////////////////////

  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      pclkPipe <= '0;
      hrefPipe <= '0;
      vsyncPipe <= '0;
    end
    else
    begin
      pclkPipe <= {pclkPipe[1:0], pclk};
      hrefPipe <= {hrefPipe[1:0], href};
      vsyncPipe <= {vsyncPipe[1:0], vsync};
    end
  end

  always_ff @(posedge CLK)
  begin
    pixMeta <= pixel;
    pixSync <= pixMeta;
  end

  assign pclkRise = pclkPipe[1] & ~pclkPipe[2];
  assign hrefRise = hrefPipe[1] & ~hrefPipe[2];
  assign hrefFall = ~hrefPipe[1] & hrefPipe[2];
  // VSYNC high marks vertical blanking
  assign vsyncRise = vsyncPipe[1] & ~vsyncPipe[2];
  assign vsyncFall = ~vsyncPipe[1] & vsyncPipe[2];

  // Only pixels inside an active line
  assign pixTake = pclkRise & hrefPipe[1];

  // First pixel may coincide with the line start
  assign colNow = hrefRise ? '0 : colCnt;

  //////////////////////////////////////////////////
  // Column and row counters
  //////////////////////////////////////////////////

  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      colCnt <= '0;
      rowCnt <= '0;
    end
    else
    begin
      // Next column, held at the last one
      if (pixTake)
        colCnt <= (colNow == trackPkg::maxCol) ? colNow : colNow + 1'b1;
      else if (hrefRise)
        colCnt <= '0;
      // Row steps at line end
      if (vsyncFall)
        rowCnt <= '0;
      else if (hrefFall && rowCnt != trackPkg::maxRow)
        rowCnt <= rowCnt + 1'b1;
    end
  end

  // Strobes
  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      pixStrobe <= 1'b0;
      frameStart <= 1'b0;
      frameEnd <= 1'b0;
    end
    else
    begin
      pixStrobe <= pixTake;
      frameStart <= vsyncFall;
      frameEnd <= vsyncRise;
    end
  end

  // Pixel payload with its position
  always_ff @(posedge CLK)
  begin
    if (pixTake)
    begin
      pixData <= pixSync;
      col <= colNow;
      row <= rowCnt;
    end
  end

endmodule

// ==== rtl/trackPkg.sv ====
package trackPkg;

  //////////////////////////////////////////////////
  // Frame geometry
  //////////////////////////////////////////////////

  // VGA sized frame from the camera
  localparam int frameWidth = 640;
  localparam int frameHeight = 480;

  // Last valid index, counters stop here
  localparam int maxCol = frameWidth - 1;
  localparam int maxRow = frameHeight - 1;

  // Coordinate widths
  localparam int colWidth = 10;
  localparam int rowWidth = 9;

  // Whole frame could match
  localparam int countWidth = 19;

  // Column sum width, row sum shares it
  localparam int sumWidth = 29;

  //////////////////////////////////////////////////
  // Pixel format and color window
  //////////////////////////////////////////////////

  // RGB565 word and its channels
  localparam int pixelWidth = 16;
  localparam int redWidth = 5;
  localparam int greenWidth = 6;
  localparam int blueWidth = 5;

  // Inclusive window for saturated red
  localparam logic [redWidth-1:0] redMin = 5'd25;
  localparam logic [redWidth-1:0] redMax = 5'd31;
  localparam logic [greenWidth-1:0] greenMin = 6'd0;
  localparam logic [greenWidth-1:0] greenMax = 6'd5;
  localparam logic [blueWidth-1:0] blueMin = 5'd0;
  localparam logic [blueWidth-1:0] blueMax = 5'd5;

  //////////////////////////////////////////////////
  // Result flow control and divider
  //////////////////////////////////////////////////

  // Credits after reset, also the ceiling
  localparam int resultCredits = 2;
  localparam int creditWidth = $clog2(resultCredits + 1);

  // One quotient bit per cycle
  localparam int divCycles = sumWidth;
  localparam int divCountWidth = $clog2(divCycles + 1);

endpackage
